//--- hdl/mips_pkg.sv
// MIPS core package
// Shared widths, selector enums, opcode and funct codes and the
// decoded control struct for the single-cycle core
package mips_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic {
        IMM_SIGN = 1'b0,
        IMM_ZERO = 1'b1
    } imm_ext_e;

    // Writeback source, loads pick their own extension
    typedef enum logic [2:0] {
        WB_ALU = 3'd0,
        WB_LUI = 3'd1,
        WB_LW  = 3'd2,
        WB_LH  = 3'd3,
        WB_LHU = 3'd4,
        WB_LB  = 3'd5,
        WB_LBU = 3'd6
    } wb_sel_e;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_BYTE = 2'd1,
        ST_HALF = 2'd2,
        ST_WORD = 2'd3
    } store_size_e;

    typedef enum logic [1:0] {
        DBG_NONE = 2'd0,
        DBG_IMEM = 2'd1,
        DBG_DMEM = 2'd2,
        DBG_REGS = 2'd3
    } debug_target_e;

    typedef struct packed {
        logic        reg_we;
        alu_op_e     alu_op;
        logic        use_imm;     // Operand 1 from immediate
        imm_ext_e    imm_ext;
        logic        shift_by_sa; // Operand 0 low bits from sa
        logic        dest_is_rt;  // I-type destination
        wb_sel_e     wb_sel;
        store_size_e store_size;
    } ctrl_t;

    // Opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

//--- hdl/mips_alu.sv
// MIPS ALU
// Combinational add, subtract, bitwise logic, set-less-than and
// logical shifts; shift amount comes from the low bits of a
`timescale 1ns/1ns

module mips_alu (
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::data_t   a,
    input  mips_pkg::data_t   b,
    output mips_pkg::data_t   result
);

    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_NOR: result = ~(a | b);
            mips_pkg::ALU_SLL: result = b << shamt;
            mips_pkg::ALU_SRL: result = b >> shamt;
            mips_pkg::ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            mips_pkg::ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            default: result = '0;
        endcase
    end

endmodule

//--- hdl/mips_reg_file.sv
// MIPS register file
// 32 general registers, two combinational read ports and one
// synchronous write port; register 0 is hardwired to zero
`timescale 1ns/1ns

module mips_reg_file (
    input  logic               mem_debug_clk_gate,
    input  logic               HW_RSTn,
    input  mips_pkg::reg_idx_t rd_idx0,
    input  mips_pkg::reg_idx_t rd_idx1,
    output mips_pkg::data_t    rd_data0,
    output mips_pkg::data_t    rd_data1,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::data_t    wr_data,
    input  logic               we
);

    mips_pkg::data_t regs [32];

    assign rd_data0 = regs[rd_idx0];
    assign rd_data1 = regs[rd_idx1];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != 5'd0)) begin // r0 never changes
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

//--- hdl/mips_instr_mem.sv
// Instruction memory
// Word store indexed by byte address / 4, wrapping at the depth;
// combinational read, synchronous debug write
`timescale 1ns/1ns

module mips_instr_mem #(
    parameter int IM_DEPTH = 32
) (
    input  logic             mem_debug_clk_gate,
    input  logic             HW_RSTn,
    input  mips_pkg::addr_t  addr,
    input  logic             we,
    input  mips_pkg::instr_t wr_data,
    output mips_pkg::instr_t rd_data
);

    localparam int IDX_W = (IM_DEPTH > 1) ? $clog2(IM_DEPTH) : 1;

    mips_pkg::instr_t mem [IM_DEPTH];
    logic [IDX_W-1:0] word_idx;

    assign word_idx = IDX_W'((addr >> 2) % IM_DEPTH);
    assign rd_data  = mem[word_idx];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < IM_DEPTH; i++) begin
                mem[i] <= '0; // Zero word decodes as a no-op
            end
        end else if (we) begin
            mem[word_idx] <= wr_data;
        end
    end

endmodule

//--- hdl/mips_data_mem.sv
// Data memory
// Word store indexed by byte address / 4 with a combinational read.
// Stores merge byte or halfword data into the low bits of the word
`timescale 1ns/1ns

module mips_data_mem #(
    parameter int DM_DEPTH = 32
) (
    input  logic                  mem_debug_clk_gate,
    input  logic                  HW_RSTn,
    input  mips_pkg::addr_t       addr,
    input  mips_pkg::store_size_e size,
    input  mips_pkg::data_t       wr_data,
    output mips_pkg::data_t       rd_data
);

    localparam int IDX_W = (DM_DEPTH > 1) ? $clog2(DM_DEPTH) : 1;

    mips_pkg::data_t  mem [DM_DEPTH];
    logic [IDX_W-1:0] word_idx;
    mips_pkg::data_t  merged;

    assign word_idx = IDX_W'((addr >> 2) % DM_DEPTH);
    assign rd_data  = mem[word_idx];

    // Read-modify-write of the addressed word
    always_comb begin
        merged = rd_data;
        case (size)
            mips_pkg::ST_BYTE: merged[7:0]  = wr_data[7:0];
            mips_pkg::ST_HALF: merged[15:0] = wr_data[15:0];
            mips_pkg::ST_WORD: merged       = wr_data;
            default:           merged       = rd_data;
        endcase
    end

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < DM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (size != mips_pkg::ST_NONE) begin
            mem[word_idx] <= merged;
        end
    end

endmodule

//--- hdl/mips_decoder.sv
// MIPS instruction decoder
// Maps opcode and funct to the control struct. Anything outside the
// supported subset gives an inactive struct and writes nothing
`timescale 1ns/1ns

module mips_decoder (
    input  logic [5:0]      opcode,
    input  logic [5:0]      funct,
    output mips_pkg::ctrl_t ctrl
);

    always_comb begin
        ctrl.reg_we      = 1'b0;
        ctrl.alu_op      = mips_pkg::ALU_ADD;
        ctrl.use_imm     = 1'b0;
        ctrl.imm_ext     = mips_pkg::IMM_SIGN;
        ctrl.shift_by_sa = 1'b0;
        ctrl.dest_is_rt  = 1'b0;
        ctrl.wb_sel      = mips_pkg::WB_ALU;
        ctrl.store_size  = mips_pkg::ST_NONE;

        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.reg_we = 1'b1; // Dropped again for unknown funct
                case (funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL: begin
                        ctrl.alu_op      = mips_pkg::ALU_SLL;
                        ctrl.shift_by_sa = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        ctrl.alu_op      = mips_pkg::ALU_SRL;
                        ctrl.shift_by_sa = 1'b1;
                    end
                    default: ctrl.reg_we = 1'b0;
                endcase
            end

            // Immediate arithmetic and logic, result to rt
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                ctrl.reg_we     = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.dest_is_rt = 1'b1;
                ctrl.imm_ext    = mips_pkg::IMM_ZERO;
                case (opcode)
                    mips_pkg::OP_ADDIU: begin
                        ctrl.alu_op  = mips_pkg::ALU_ADD;
                        ctrl.imm_ext = mips_pkg::IMM_SIGN;
                    end
                    mips_pkg::OP_SLTI: begin
                        ctrl.alu_op  = mips_pkg::ALU_SLT;
                        ctrl.imm_ext = mips_pkg::IMM_SIGN;
                    end
                    mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
                    default:            ctrl.alu_op = mips_pkg::ALU_XOR;
                endcase
            end

            mips_pkg::OP_LUI: begin
                ctrl.reg_we     = 1'b1;
                ctrl.dest_is_rt = 1'b1;
                ctrl.wb_sel     = mips_pkg::WB_LUI;
            end

            // Loads, address is rs + sign-extended offset
            mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LHU,
            mips_pkg::OP_LB, mips_pkg::OP_LBU: begin
                ctrl.reg_we     = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.dest_is_rt = 1'b1;
                case (opcode)
                    mips_pkg::OP_LW:  ctrl.wb_sel = mips_pkg::WB_LW;
                    mips_pkg::OP_LH:  ctrl.wb_sel = mips_pkg::WB_LH;
                    mips_pkg::OP_LHU: ctrl.wb_sel = mips_pkg::WB_LHU;
                    mips_pkg::OP_LB:  ctrl.wb_sel = mips_pkg::WB_LB;
                    default:          ctrl.wb_sel = mips_pkg::WB_LBU;
                endcase
            end

            mips_pkg::OP_SW: begin
                ctrl.use_imm    = 1'b1;
                ctrl.store_size = mips_pkg::ST_WORD;
            end
            mips_pkg::OP_SH: begin
                ctrl.use_imm    = 1'b1;
                ctrl.store_size = mips_pkg::ST_HALF;
            end
            mips_pkg::OP_SB: begin
                ctrl.use_imm    = 1'b1;
                ctrl.store_size = mips_pkg::ST_BYTE;
            end

            default: ; // Unsupported, all controls inactive
        endcase
    end

endmodule

//--- hdl/mips_core_top.sv
// Single-cycle MIPS subset core
// Run mode executes one instruction per clock from RESET_PC upwards.
// Debug mode (mem_debug high) holds the PC at RESET_PC and gives a
// host read and write access to instruction memory, data memory and
// the register file over one shared addr/din/dout port
`timescale 1ns/1ns

module mips_core_top #(
    parameter int              IM_DEPTH = 32,
    parameter int              DM_DEPTH = 32,
    parameter mips_pkg::addr_t RESET_PC = '0
) (
    input  logic                    mem_debug_clk_gate,
    input  logic                    HW_RSTn,
    input  logic                    mem_debug,
    input  mips_pkg::debug_target_e debug_func,
    input  logic                    debug_we,
    input  mips_pkg::addr_t         addr,
    input  mips_pkg::data_t         din,
    output mips_pkg::data_t         dout
);

    mips_pkg::addr_t    pc;
    mips_pkg::instr_t   instr;
    mips_pkg::ctrl_t    ctrl;

    logic [5:0]         opcode;
    logic [5:0]         funct;
    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    mips_pkg::reg_idx_t rd;
    logic [4:0]         sa;
    logic [15:0]        imm;

    mips_pkg::addr_t    im_addr;
    logic               im_we;
    mips_pkg::reg_idx_t rf_rd_idx1;
    mips_pkg::reg_idx_t rf_wr_idx;
    mips_pkg::data_t    rf_wr_data;
    logic               rf_we;
    mips_pkg::data_t    rs_val;
    mips_pkg::data_t    rt_val;

    mips_pkg::data_t       imm_val;
    mips_pkg::data_t       alu_a;
    mips_pkg::data_t       alu_b;
    mips_pkg::data_t       alu_result;
    mips_pkg::addr_t       dm_addr;
    mips_pkg::store_size_e dm_size;
    mips_pkg::data_t       dm_wr_data;
    mips_pkg::data_t       dm_rd_data;
    mips_pkg::data_t       wb_data;

    // PC parks at RESET_PC for the whole debug session
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= RESET_PC;
        end else if (mem_debug) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign sa     = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    // Debug steering, run-mode writes are blocked while mem_debug is high
    assign im_addr    = mem_debug ? addr : pc;
    assign im_we      = mem_debug && debug_we && (debug_func == mips_pkg::DBG_IMEM);
    assign rf_rd_idx1 = mem_debug ? addr[4:0] : rt;
    assign rf_wr_idx  = mem_debug ? addr[4:0] : (ctrl.dest_is_rt ? rt : rd);
    assign rf_wr_data = mem_debug ? din : wb_data;
    assign rf_we      = mem_debug ? (debug_we && (debug_func == mips_pkg::DBG_REGS))
                                  : ctrl.reg_we;
    assign dm_addr    = mem_debug ? addr : alu_result;
    assign dm_wr_data = mem_debug ? din : rt_val;
    assign dm_size    = !mem_debug ? ctrl.store_size
                      : (debug_we && (debug_func == mips_pkg::DBG_DMEM)) ? mips_pkg::ST_WORD
                      : mips_pkg::ST_NONE;

    // Operand build
    assign imm_val = (ctrl.imm_ext == mips_pkg::IMM_SIGN) ? {{16{imm[15]}}, imm}
                                                           : {16'd0, imm};
    assign alu_a   = {rs_val[31:5], ctrl.shift_by_sa ? sa : rs_val[4:0]};
    assign alu_b   = ctrl.use_imm ? imm_val : rt_val;

    // Writeback select, sub-word loads take the low bits of the word
    always_comb begin
        case (ctrl.wb_sel)
            mips_pkg::WB_LUI: wb_data = {imm, 16'd0};
            mips_pkg::WB_LW:  wb_data = dm_rd_data;
            mips_pkg::WB_LH:  wb_data = {{16{dm_rd_data[15]}}, dm_rd_data[15:0]};
            mips_pkg::WB_LHU: wb_data = {16'd0, dm_rd_data[15:0]};
            mips_pkg::WB_LB:  wb_data = {{24{dm_rd_data[7]}}, dm_rd_data[7:0]};
            mips_pkg::WB_LBU: wb_data = {24'd0, dm_rd_data[7:0]};
            default:          wb_data = alu_result;
        endcase
    end

    // Host readback
    always_comb begin
        case (debug_func)
            mips_pkg::DBG_IMEM: dout = instr;
            mips_pkg::DBG_DMEM: dout = dm_rd_data;
            mips_pkg::DBG_REGS: dout = rt_val; // Port 1 is on addr[4:0] in debug
            default:            dout = '0;
        endcase
    end

    mips_instr_mem #(
        .IM_DEPTH (IM_DEPTH)
    ) u_instr_mem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .addr               (im_addr),
        .we                 (im_we),
        .wr_data            (din),
        .rd_data            (instr)
    );

    mips_decoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    mips_reg_file u_reg_file (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .rd_idx0            (rs),
        .rd_idx1            (rf_rd_idx1),
        .rd_data0           (rs_val),
        .rd_data1           (rt_val),
        .wr_idx             (rf_wr_idx),
        .wr_data            (rf_wr_data),
        .we                 (rf_we)
    );

    mips_alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    mips_data_mem #(
        .DM_DEPTH (DM_DEPTH)
    ) u_data_mem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .addr               (dm_addr),
        .size               (dm_size),
        .wr_data            (dm_wr_data),
        .rd_data            (dm_rd_data)
    );

endmodule

//--- sim/mips_core_assertions.sv
// Debug port checks for the MIPS core
// Bound into the top level, watches the host port only
`timescale 1ns/1ns

module mips_core_assertions (
    input logic                    mem_debug_clk_gate,
    input logic                    HW_RSTn,
    input logic                    mem_debug,
    input mips_pkg::debug_target_e debug_func,
    input logic                    debug_we,
    input mips_pkg::addr_t         addr,
    input mips_pkg::data_t         din,
    input mips_pkg::data_t         dout
);

    int error_count = 0;

    property none_reads_zero;
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
            (debug_func == mips_pkg::DBG_NONE) |-> (dout == '0);
    endproperty

    property reg0_reads_zero;
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
            (debug_func == mips_pkg::DBG_REGS && addr[4:0] == 5'd0) |-> (dout == '0);
    endproperty

    // IMEM write on one edge, same address read on the next
    property imem_write_readback;
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
            (mem_debug && debug_func == mips_pkg::DBG_IMEM
             && $past(mem_debug && debug_we && debug_func == mips_pkg::DBG_IMEM)
             && addr == $past(addr))
            |-> (dout == $past(din));
    endproperty

    assert property (none_reads_zero)
        else begin
            $error("dout is not zero with no debug target selected");
            error_count++;
        end
    assert property (reg0_reads_zero)
        else begin
            $error("register 0 read back nonzero");
            error_count++;
        end
    assert property (imem_write_readback)
        else begin
            $error("instruction memory readback differs from the word just written");
            error_count++;
        end

endmodule

bind mips_core_top mips_core_assertions u_assertions (
    .mem_debug_clk_gate (mem_debug_clk_gate),
    .HW_RSTn            (HW_RSTn),
    .mem_debug          (mem_debug),
    .debug_func         (debug_func),
    .debug_we           (debug_we),
    .addr               (addr),
    .din                (din),
    .dout               (dout)
);

//--- sim/tb_mips_core.sv
// Testbench for the single-cycle MIPS subset core
// Loads operands and programs over the debug port, runs them and
// compares registers and data memory against a local model
`timescale 1ns/1ns

module tb_mips_core;

    localparam int DEPTH = 32; // Model indexing below assumes 32 words
    // Debug writes, run cycles and readbacks over all tests, plus margin
    localparam int CYCLE_LIMIT = 39 + 25 + 62 + 50;

    logic                    mem_debug_clk_gate;
    logic                    HW_RSTn;
    logic                    mem_debug;
    mips_pkg::debug_target_e debug_func;
    logic                    debug_we;
    mips_pkg::addr_t         addr;
    mips_pkg::data_t         din;
    mips_pkg::data_t         dout;

    mips_pkg::data_t  reg_model [32];
    mips_pkg::data_t  dmem_model [DEPTH];
    mips_pkg::instr_t prog_q [$];
    int               seed = 32'h9624;
    int               cycle_count = 0;
    int               pass_count = 0;
    int               fail_count = 0;
    int               test_errors = 0;

    logic [5:0] rtype_functs [8] = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
        mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
    string rtype_names [10] = '{"ADDU", "SUBU", "AND", "OR", "XOR", "NOR", "SLT", "SLTU",
        "SLL", "SRL"};
    string itype_names [7] = '{"ADDIU", "SLTI", "SLTIU", "ANDI", "ORI", "XORI", "LUI"};
    string load_names [5] = '{"LW", "LH", "LHU", "LB", "LBU"};

    mips_core_top #(
        .IM_DEPTH (DEPTH),
        .DM_DEPTH (DEPTH),
        .RESET_PC ('0)
    ) uut (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .mem_debug          (mem_debug),
        .debug_func         (debug_func),
        .debug_we           (debug_we),
        .addr               (addr),
        .din                (din),
        .dout               (dout)
    );

    initial mem_debug_clk_gate = 1'b0;
    always #50 mem_debug_clk_gate = ~mem_debug_clk_gate;

    always @(posedge mem_debug_clk_gate) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [4:0] word_index(input mips_pkg::addr_t a);
        return a[6:2]; // Byte address / 4, modulo 32 words
    endfunction

    function automatic mips_pkg::data_t sign_extend16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic void set_reg(input mips_pkg::reg_idx_t idx, input mips_pkg::data_t v);
        if (idx != 5'd0) begin
            reg_model[idx] = v;
        end
    endfunction

    function automatic mips_pkg::instr_t encode_rtype(input logic [5:0] fn,
        input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt,
        input mips_pkg::reg_idx_t rd, input logic [4:0] sa);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic mips_pkg::instr_t encode_itype(input logic [5:0] op,
        input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic debug_write(input mips_pkg::debug_target_e target,
                               input mips_pkg::addr_t a, input mips_pkg::data_t d);
        @(negedge mem_debug_clk_gate);
        mem_debug  = 1'b1;
        debug_func = target;
        debug_we   = 1'b1;
        addr       = a;
        din        = d;
        case (target)
            mips_pkg::DBG_DMEM: dmem_model[word_index(a)] = d;
            mips_pkg::DBG_REGS: set_reg(a[4:0], d);
            default: ;
        endcase
    endtask

    task automatic read_expect(input string name, input mips_pkg::debug_target_e target,
                               input mips_pkg::addr_t a, input mips_pkg::data_t expected);
        @(negedge mem_debug_clk_gate);
        mem_debug  = 1'b1;
        debug_func = target;
        debug_we   = 1'b0;
        addr       = a;
        #20; // Combinational readback, settled well before the edge
        assert (dout === expected) begin
            pass_count++;
        end else begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, dout);
            fail_count++;
            test_errors++;
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_idx_t idx);
        read_expect(name, mips_pkg::DBG_REGS, {27'd0, idx}, reg_model[idx]);
    endtask

    task automatic check_dmem(input string name, input mips_pkg::addr_t a);
        read_expect(name, mips_pkg::DBG_DMEM, a, dmem_model[word_index(a)]);
    endtask

    // Program goes to IMEM from address 0, then one edge per instruction
    task automatic run_program();
        int n;
        n = prog_q.size();
        foreach (prog_q[i]) begin
            debug_write(mips_pkg::DBG_IMEM, mips_pkg::addr_t'(i * 4), prog_q[i]);
        end
        @(negedge mem_debug_clk_gate);
        mem_debug  = 1'b0;
        debug_we   = 1'b0;
        debug_func = mips_pkg::DBG_NONE;
        repeat (n) @(posedge mem_debug_clk_gate);
        @(negedge mem_debug_clk_gate);
        mem_debug = 1'b1;
        prog_q.delete();
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        mips_pkg::data_t a;
        mips_pkg::data_t b;
        mips_pkg::data_t w;
        logic [4:0]      sa;
        logic [15:0]     imm_s;
        logic [15:0]     imm_z;

        HW_RSTn    = 1'b0;
        mem_debug  = 1'b1;
        debug_func = mips_pkg::DBG_NONE;
        debug_we   = 1'b0;
        addr       = '0;
        din        = '0;
        foreach (reg_model[i]) reg_model[i] = '0;
        foreach (dmem_model[i]) dmem_model[i] = '0;
        repeat (3) @(negedge mem_debug_clk_gate);
        HW_RSTn = 1'b1;

        // Debug port access on all three targets
        w = $random(seed);
        debug_write(mips_pkg::DBG_IMEM, 32'h50, w);
        read_expect("imem readback", mips_pkg::DBG_IMEM, 32'h50, w);
        debug_write(mips_pkg::DBG_DMEM, 32'h10, $random(seed));
        check_dmem("dmem readback", 32'h10);
        debug_write(mips_pkg::DBG_REGS, 32'd5, $random(seed));
        check_reg("reg readback", 5'd5);
        read_expect("no target", mips_pkg::DBG_NONE, 32'h10, '0);
        debug_write(mips_pkg::DBG_REGS, 32'd0, $random(seed));
        check_reg("reg0 write", 5'd0);
        finish_test("debug_access");

        // R-type, r1 and r2 as sources, results in r3..r12
        a  = $random(seed);
        b  = $random(seed);
        sa = 5'($random(seed));
        debug_write(mips_pkg::DBG_REGS, 32'd1, a);
        debug_write(mips_pkg::DBG_REGS, 32'd2, b);
        for (int i = 0; i < 8; i++) begin
            prog_q.push_back(encode_rtype(rtype_functs[i], 5'd1, 5'd2, 5'(i + 3), 5'd0));
        end
        prog_q.push_back(encode_rtype(mips_pkg::FN_SLL, 5'd0, 5'd2, 5'd11, sa));
        prog_q.push_back(encode_rtype(mips_pkg::FN_SRL, 5'd0, 5'd2, 5'd12, sa));
        run_program();
        set_reg(5'd3, a + b);
        set_reg(5'd4, a - b);
        set_reg(5'd5, a & b);
        set_reg(5'd6, a | b);
        set_reg(5'd7, a ^ b);
        set_reg(5'd8, ~(a | b));
        set_reg(5'd9, {31'd0, $signed(a) < $signed(b)});
        set_reg(5'd10, {31'd0, a < b});
        set_reg(5'd11, b << sa);
        set_reg(5'd12, b >> sa);
        for (int i = 0; i < 10; i++) begin
            check_reg(rtype_names[i], 5'(i + 3));
        end
        finish_test("rtype_program");

        // I-type with bit 15 set so the extension kind shows
        a     = $random(seed);
        b     = {2'b10, 30'($random(seed))}; // Negative, upper half below 16'hffff
        imm_s = 16'($random(seed)) | 16'h8000;
        imm_z = 16'($random(seed)) | 16'h8000;
        debug_write(mips_pkg::DBG_REGS, 32'd1, a);
        debug_write(mips_pkg::DBG_REGS, 32'd2, b);
        prog_q.push_back(encode_itype(mips_pkg::OP_ADDIU, 5'd1, 5'd13, imm_s));
        prog_q.push_back(encode_itype(mips_pkg::OP_SLTI, 5'd0, 5'd14, imm_s)); // Zero vs imm
        prog_q.push_back(encode_itype(mips_pkg::OP_SLTIU, 5'd2, 5'd15, imm_z));
        prog_q.push_back(encode_itype(mips_pkg::OP_ANDI, 5'd1, 5'd16, imm_z));
        prog_q.push_back(encode_itype(mips_pkg::OP_ORI, 5'd1, 5'd17, imm_z));
        prog_q.push_back(encode_itype(mips_pkg::OP_XORI, 5'd1, 5'd18, imm_z));
        prog_q.push_back(encode_itype(mips_pkg::OP_LUI, 5'd0, 5'd19, imm_z));
        run_program();
        set_reg(5'd13, a + sign_extend16(imm_s));
        set_reg(5'd14, {31'd0, 32'sd0 < $signed(sign_extend16(imm_s))});
        set_reg(5'd15, {31'd0, b < {16'd0, imm_z}});
        set_reg(5'd16, a & {16'd0, imm_z});
        set_reg(5'd17, a | {16'd0, imm_z});
        set_reg(5'd18, a ^ {16'd0, imm_z});
        set_reg(5'd19, {imm_z, 16'd0});
        for (int i = 0; i < 7; i++) begin
            check_reg(itype_names[i], 5'(i + 13));
        end
        finish_test("itype_program");

        // Stores, SB offset 11 lands in the word at 0x28
        debug_write(mips_pkg::DBG_DMEM, 32'h24, $random(seed));
        debug_write(mips_pkg::DBG_DMEM, 32'h28, $random(seed));
        debug_write(mips_pkg::DBG_REGS, 32'd20, 32'h20);
        w = $random(seed);
        debug_write(mips_pkg::DBG_REGS, 32'd21, w);
        prog_q.push_back(encode_itype(mips_pkg::OP_SW, 5'd20, 5'd21, 16'd0));
        prog_q.push_back(encode_itype(mips_pkg::OP_SH, 5'd20, 5'd21, 16'd4));
        prog_q.push_back(encode_itype(mips_pkg::OP_SB, 5'd20, 5'd21, 16'd11));
        run_program();
        dmem_model[word_index(32'h20)]       = w;
        dmem_model[word_index(32'h24)][15:0] = w[15:0];
        dmem_model[word_index(32'h2b)][7:0]  = w[7:0];
        check_dmem("SW", 32'h20);
        check_dmem("SH", 32'h24);
        check_dmem("SB", 32'h28);
        finish_test("stores");

        // Loads from one word with both sign bits set
        w = $random(seed) | 32'h0000_8080;
        debug_write(mips_pkg::DBG_DMEM, 32'h40, w);
        debug_write(mips_pkg::DBG_REGS, 32'd22, 32'h40);
        prog_q.push_back(encode_itype(mips_pkg::OP_LW, 5'd22, 5'd23, 16'd0));
        prog_q.push_back(encode_itype(mips_pkg::OP_LH, 5'd22, 5'd24, 16'd0));
        prog_q.push_back(encode_itype(mips_pkg::OP_LHU, 5'd22, 5'd25, 16'd2));
        prog_q.push_back(encode_itype(mips_pkg::OP_LB, 5'd22, 5'd26, 16'd3));
        prog_q.push_back(encode_itype(mips_pkg::OP_LBU, 5'd22, 5'd27, 16'd1));
        run_program();
        set_reg(5'd23, w);
        set_reg(5'd24, sign_extend16(w[15:0]));
        set_reg(5'd25, {16'd0, w[15:0]});
        set_reg(5'd26, {{24{w[7]}}, w[7:0]});
        set_reg(5'd27, {24'd0, w[7:0]});
        for (int i = 0; i < 5; i++) begin
            check_reg(load_names[i], 5'(i + 23));
        end
        finish_test("loads");

        // Reset pulse clears registers and data memory
        @(negedge mem_debug_clk_gate);
        HW_RSTn = 1'b0;
        @(negedge mem_debug_clk_gate);
        HW_RSTn = 1'b1;
        foreach (reg_model[i]) reg_model[i] = '0;
        foreach (dmem_model[i]) dmem_model[i] = '0;
        for (int r = 1; r < 28; r++) begin
            check_reg("reset reg", 5'(r));
        end
        check_dmem("reset dmem", 32'h10);
        check_dmem("reset dmem", 32'h20);
        check_dmem("reset dmem", 32'h24);
        check_dmem("reset dmem", 32'h28);
        check_dmem("reset dmem", 32'h40);
        finish_test("reset");

        $display("checks passed: %0d, failed: %0d, assertion errors: %0d",
                 pass_count, fail_count, uut.u_assertions.error_count);
        if (fail_count == 0 && uut.u_assertions.error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_reg_file.sv
hdl/mips_instr_mem.sv
hdl/mips_data_mem.sv
hdl/mips_decoder.sv
hdl/mips_core_top.sv
sim/mips_core_assertions.sv
sim/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MIPS core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 --top-module tb_mips_core \
    -f filelist.f -o tb_mips_core

# Keep running past assertion errors so the testbench can report them
output="$(./obj_dir/tb_mips_core +verilator+error+limit+100)" || true
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
